// File: build.f
trs_pkg.sv
pin_sync.sv
spi_slave.sv
cmd_parser.sv
cmd_exec.sv
z80_mem_port.sv
dual_port_ram.sv
trs_io_top.sv
trs_io_tb.sv

// File: trs_io_tb.sv
`timescale 1ns/100ps
`default_nettype none

module trs_io_tb;

  localparam int half       = 10;          // sck half period in clk cycles
  localparam int byte_cycles = 16 * half;
  localparam int msg_cycles  = 3 * half + 1; // cs setup, hold, idle
  localparam int acc_cycles  = 17;          // 12 low, 4 high, 1 align

  localparam int n_pokes = 40;
  localparam int n_bus   = 16;
  localparam int n_map   = 8;
  localparam int n_led   = 4;
  localparam int n_abort = 4;

  localparam int total_bytes = 8 + n_pokes * 8 + n_bus * 8 + n_map * 20 + 2
                               + n_led * 2 + n_abort * 13;
  localparam int total_msgs  = 4 + n_pokes * 2 + n_bus * 2 + n_map * 5 + 1
                               + n_led + n_abort * 4;
  localparam int total_acc   = n_bus * 2 + n_map * 6;
  localparam int est_cycles  = total_bytes * byte_cycles + total_msgs * msg_cycles
                               + total_acc * acc_cycles + 100;
  localparam int timeout_cycles = est_cycles + est_cycles / 4;

  logic               clk;
  logic               reset;
  trs_pkg::spi_pins_t spi;
  logic               miso;
  logic [15:0]        addr;
  trs_pkg::z80_ctrl_t ctrl;
  logic [7:0]         data_in;
  logic [7:0]         data_out;
  logic               data_oe;
  logic [3:0]         conf;
  logic [2:0]         led;

  logic [7:0]  model [32768]; // shared ram contents as the host sees them
  logic [31:0] rng;
  int          err_cnt;
  int          check_cnt;
  int          cycle_cnt;

  trs_io_top #(.filter_len(3), .addr_w(15)) dut0 (
    .clk      (clk),
    .reset    (reset),
    .spi      (spi),
    .miso     (miso),
    .addr     (addr),
    .ctrl     (ctrl),
    .data_in  (data_in),
    .data_out (data_out),
    .data_oe  (data_oe),
    .conf     (conf),
    .led      (led)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    if (err_cnt == errs_at_start)
      $display("%s: ok", name);
    else
      $display("%s: %0d errors", name, err_cnt - errs_at_start);
  endtask

  // spi host, mode 0, msb first
  task automatic msg_begin();
    @(negedge clk);
    spi.cs_n = 1'b0;
    repeat (half) @(negedge clk);
  endtask

  task automatic msg_end();
    repeat (half) @(negedge clk);
    spi.cs_n = 1'b1;
    repeat (half) @(negedge clk);
  endtask

  task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      spi.mosi = tx[i];
      repeat (half) @(negedge clk);
      rx[i]   = miso; // sampled just before the rise
      spi.sck = 1'b1;
      repeat (half) @(negedge clk);
      spi.sck = 1'b0;
    end
  endtask

  task automatic query(input logic [7:0] cmd, output logic [7:0] r);
    logic [7:0] junk;
    msg_begin();
    spi_xfer(cmd, junk);
    spi_xfer(8'h00, r); // dummy byte carries the reply
    msg_end();
  endtask

  task automatic write_reg(input logic [7:0] cmd, input logic [7:0] val);
    logic [7:0] junk;
    msg_begin();
    spi_xfer(cmd, junk);
    spi_xfer(val, junk);
    msg_end();
  endtask

  task automatic spi_poke(input logic [14:0] a, input logic [7:0] d);
    logic [7:0] junk;
    msg_begin();
    spi_xfer(8'(trs_pkg::bram_poke), junk);
    spi_xfer(a[7:0], junk);
    spi_xfer({1'b0, a[14:8]}, junk);
    spi_xfer(d, junk);
    msg_end();
    model[a] = d;
  endtask

  task automatic spi_peek(input logic [14:0] a, output logic [7:0] d);
    logic [7:0] junk;
    msg_begin();
    spi_xfer(8'(trs_pkg::bram_peek), junk);
    spi_xfer(a[7:0], junk);
    spi_xfer({1'b0, a[14:8]}, junk);
    spi_xfer(8'h00, d);
    msg_end();
  endtask

  // z80 bus cycles, strobe held 12 cycles then 4 high
  task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
    @(negedge clk);
    addr      = a;
    data_in   = d;
    ctrl.wr_n = 1'b0;
    repeat (12) @(negedge clk);
    ctrl.wr_n = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  task automatic bus_read(input logic [15:0] a, output logic [7:0] d, output logic oe);
    @(negedge clk);
    addr      = a;
    ctrl.rd_n = 1'b0;
    repeat (12) @(negedge clk);
    d         = data_out;
    oe        = data_oe;
    ctrl.rd_n = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  task automatic test_identity();
    logic [31:0] r;
    logic [7:0]  got;
    int          errs0;
    errs0 = err_cnt;
    r     = next_rand();
    conf  = r[3:0];
    query(8'(trs_pkg::get_cookie), got);
    check("reply cookie", got, 8'haf);
    query(8'(trs_pkg::get_version), got);
    check("reply version", got, 8'h03);
    query(8'(trs_pkg::get_config), got);
    check("reply config", got, {4'h0, r[3:0]});
    conf = ~r[3:0]; // each conf bit seen at both levels
    query(8'(trs_pkg::get_config), got);
    check("reply config", got, {4'h0, ~r[3:0]});
    report_test("test 1 identity replies", errs0);
  endtask

  task automatic test_poke_peek();
    logic [14:0] addrs [n_pokes];
    int          order [n_pokes];
    logic [31:0] r;
    logic [7:0]  got;
    int          j;
    int          tmp;
    int          errs0;
    errs0 = err_cnt;
    for (int i = 0; i < n_pokes; i++) begin
      r        = next_rand();
      addrs[i] = r[14:0];
      order[i] = i;
      spi_poke(r[14:0], r[23:16]);
    end
    // shuffle the peek order
    for (int i = n_pokes - 1; i > 0; i--) begin
      r        = next_rand();
      j        = int'(r % (i + 1));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < n_pokes; i++) begin
      spi_peek(addrs[order[i]], got);
      check("peek reply", got, model[addrs[order[i]]]);
    end
    report_test("test 2 spi poke and peek", errs0);
  endtask

  task automatic test_bus_sharing();
    logic [31:0] r;
    logic [15:0] a;
    logic [7:0]  got;
    logic        oe;
    int          errs0;
    errs0 = err_cnt;
    for (int i = 0; i < n_bus; i++) begin
      r = next_rand();
      a = {1'b1, r[14:0]}; // upper 32k
      bus_write(a, r[31:24]);
      model[a[14:0]] = r[31:24];
      spi_peek(a[14:0], got);
      check("peek after bus write", got, model[a[14:0]]);
    end
    for (int i = 0; i < n_bus; i++) begin
      r = next_rand();
      spi_poke(r[14:0], r[23:16]);
      bus_read({1'b1, r[14:0]}, got, oe);
      check("data_out", got, model[r[14:0]]);
      check("data_oe", {7'h00, oe}, 8'h01);
    end
    report_test("test 3 bus and spi share ram", errs0);
  endtask

  task automatic test_memory_map();
    logic [15:0] lo_addrs [n_map];
    logic [31:0] r;
    logic [15:0] a;
    logic [7:0]  got;
    logic        oe;
    int          errs0;
    errs0 = err_cnt;
    // 0x4000..0x7fff is not decoded in the original map
    for (int i = 0; i < n_map; i++) begin
      r           = next_rand();
      a           = {2'b01, r[13:0]};
      lo_addrs[i] = a;
      spi_poke(a[14:0], r[23:16]);
      bus_write(a, ~r[23:16]);
      bus_read(a, got, oe);
      check("data_oe", {7'h00, oe}, 8'h00);
      spi_peek(a[14:0], got);
      check("peek after ignored write", got, model[a[14:0]]);
    end
    write_reg(8'(trs_pkg::set_full_addr), 8'h01);
    for (int i = 0; i < n_map; i++) begin
      r = next_rand();
      a = lo_addrs[i];
      bus_write(a, r[7:0]);
      model[a[14:0]] = r[7:0];
      spi_peek(a[14:0], got);
      check("peek after full map write", got, model[a[14:0]]);
      bus_read(a, got, oe);
      check("data_out", got, model[a[14:0]]);
      check("data_oe", {7'h00, oe}, 8'h01);
    end
    // rom window below 0x3000 reads the ram, writes are dropped
    for (int i = 0; i < n_map; i++) begin
      r = next_rand();
      a = r[15:0] % 16'h3000;
      spi_poke(a[14:0], r[23:16]);
      bus_read(a, got, oe);
      check("data_out", got, model[a[14:0]]);
      check("data_oe", {7'h00, oe}, 8'h01);
      bus_write(a, ~r[23:16]);
      spi_peek(a[14:0], got);
      check("peek after rom write", got, model[a[14:0]]);
    end
    report_test("test 4 memory map decode", errs0);
  endtask

  task automatic test_led();
    logic [31:0] r;
    int          errs0;
    errs0 = err_cnt;
    for (int i = 0; i < n_led; i++) begin
      r = next_rand();
      write_reg(8'(trs_pkg::set_led), r[7:0]);
      check("led", {5'h00, led}, {5'h00, r[2:0]});
    end
    report_test("test 5 led register", errs0);
  endtask

  task automatic test_abort();
    logic [31:0] r;
    logic [14:0] a;
    logic [7:0]  got;
    logic [7:0]  junk;
    int          errs0;
    errs0 = err_cnt;
    for (int i = 0; i < n_abort; i++) begin
      r = next_rand();
      a = r[14:0];
      spi_poke(a, r[23:16]);
      msg_begin();
      spi_xfer(8'(trs_pkg::bram_poke), junk);
      spi_xfer(a[7:0], junk);
      spi_xfer({1'b0, a[14:8]}, junk);
      msg_end(); // cs_n rises before the data byte
      spi_peek(a, got);
      check("peek after aborted poke", got, model[a]);
      query(8'(trs_pkg::get_version), got); // reply differs from the cookie left by the dummy
      check("reply version", got, 8'h03);
    end
    report_test("test 6 aborted message", errs0);
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the tests did not complete", cycle_cnt);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    rng       = 32'h5d56_137c;
    err_cnt   = 0;
    check_cnt = 0;
    reset     = 1'b1;
    spi.sck   = 1'b0;
    spi.cs_n  = 1'b1;
    spi.mosi  = 1'b0;
    ctrl.rd_n = 1'b1;
    ctrl.wr_n = 1'b1;
    addr      = 16'h0000;
    data_in   = 8'h00;
    conf      = 4'h0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    repeat (4) @(negedge clk);

    test_identity();
    test_poke_peek();
    test_bus_sharing();
    test_memory_map();
    test_led();
    test_abort();

    $display("tests 6, checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: trs_io_top.sv
`timescale 1ns/100ps
`default_nettype none

module trs_io_top #(
  parameter int filter_len = 3,
  parameter int addr_w     = 15
) (
  input  logic               clk,
  input  logic               reset,
  input  trs_pkg::spi_pins_t spi,
  output logic               miso,
  input  logic [15:0]        addr,
  input  trs_pkg::z80_ctrl_t ctrl,
  input  logic [7:0]         data_in,
  output logic [7:0]         data_out,
  output logic               data_oe,
  input  logic [3:0]         conf,
  output logic [2:0]         led
);

  logic [7:0]        byte_in;
  logic              byte_valid;
  logic              msg_start;
  logic [7:0]        reply;
  trs_pkg::cmd_req_t req;
  logic              full_addr;

  // port a, z80 bus
  logic              a_en;
  logic              a_we;
  logic [addr_w-1:0] a_addr;
  logic [7:0]        a_wdata;
  logic [7:0]        a_rdata;

  // port b, host link
  logic              b_en;
  logic              b_we;
  logic [addr_w-1:0] b_addr;
  logic [7:0]        b_wdata;
  logic [7:0]        b_rdata;

  spi_slave spi0 (
    .clk        (clk),
    .reset      (reset),
    .spi        (spi),
    .miso       (miso),
    .reply      (reply),
    .byte_in    (byte_in),
    .byte_valid (byte_valid),
    .msg_start  (msg_start)
  );

  cmd_parser parser0 (
    .clk        (clk),
    .reset      (reset),
    .byte_in    (byte_in),
    .byte_valid (byte_valid),
    .msg_start  (msg_start),
    .req        (req)
  );

  cmd_exec exec0 (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .conf      (conf),
    .reply     (reply),
    .led       (led),
    .full_addr (full_addr),
    .ram_en    (b_en),
    .ram_we    (b_we),
    .ram_addr  (b_addr),
    .ram_wdata (b_wdata),
    .ram_rdata (b_rdata)
  );

  z80_mem_port #(
    .filter_len (filter_len),
    .addr_w     (addr_w)
  ) z80_0 (
    .clk       (clk),
    .reset     (reset),
    .addr      (addr),
    .ctrl      (ctrl),
    .data_in   (data_in),
    .full_addr (full_addr),
    .data_out  (data_out),
    .data_oe   (data_oe),
    .ram_en    (a_en),
    .ram_we    (a_we),
    .ram_addr  (a_addr),
    .ram_wdata (a_wdata),
    .ram_rdata (a_rdata)
  );

  dual_port_ram #(.addr_w(addr_w)) ram0 (
    .clk     (clk),
    .a_en    (a_en),
    .a_we    (a_we),
    .a_addr  (a_addr),
    .a_wdata (a_wdata),
    .a_rdata (a_rdata),
    .b_en    (b_en),
    .b_we    (b_we),
    .b_addr  (b_addr),
    .b_wdata (b_wdata),
    .b_rdata (b_rdata)
  );

endmodule

`default_nettype wire

// File: dual_port_ram.sv
`timescale 1ns/100ps
`default_nettype none

module dual_port_ram #(
  parameter int addr_w = 15
) (
  input  logic              clk,
  input  logic              a_en,
  input  logic              a_we,
  input  logic [addr_w-1:0] a_addr,
  input  logic [7:0]        a_wdata,
  output logic [7:0]        a_rdata,
  input  logic              b_en,
  input  logic              b_we,
  input  logic [addr_w-1:0] b_addr,
  input  logic [7:0]        b_wdata,
  output logic [7:0]        b_rdata
);

  logic [7:0] mem [2**addr_w];

  // z80 side
  always @(posedge clk) begin
    if (a_en) begin
      if (a_we) begin
        mem[a_addr] <= a_wdata;
        a_rdata     <= a_wdata; // write first
      end else begin
        a_rdata <= mem[a_addr];
      end
    end
  end

  // spi side
  always @(posedge clk) begin
    if (b_en) begin
      if (b_we) begin
        mem[b_addr] <= b_wdata;
        b_rdata     <= b_wdata;
      end else begin
        b_rdata <= mem[b_addr];
      end
    end
  end

  a_no_write_clash: assert property (
    @(posedge clk) !(a_en && a_we && b_en && b_we && (a_addr == b_addr))
  );

endmodule

`default_nettype wire

// File: z80_mem_port.sv
`timescale 1ns/100ps
`default_nettype none

module z80_mem_port #(
  parameter int filter_len = 3,
  parameter int addr_w     = 15
) (
  input  logic               clk,
  input  logic               reset,
  input  logic [15:0]        addr,
  input  trs_pkg::z80_ctrl_t ctrl,
  input  logic [7:0]         data_in,
  input  logic               full_addr,
  output logic [7:0]         data_out,
  output logic               data_oe,
  output logic               ram_en,
  output logic               ram_we,
  output logic [addr_w-1:0]  ram_addr,
  output logic [7:0]         ram_wdata,
  input  logic [7:0]         ram_rdata
);

  localparam int cnt_w = $clog2(filter_len + 1);

  trs_pkg::z80_ctrl_t strobe;
  trs_pkg::z80_ctrl_t strobe_prev;
  logic [cnt_w-1:0]   low_cnt;
  logic               low;
  logic               stable;
  logic               recog;
  logic               rom_sel;
  logic               ram_sel;
  logic               rd_go;
  logic               wr_go;
  logic               rd_s1;
  logic               rd_s2;

  pin_sync #(.T(trs_pkg::z80_ctrl_t)) sync0 (
    .clk  (clk),
    .in   (ctrl),
    .sync (strobe),
    .prev (strobe_prev)
  );

  assign low    = ~strobe.rd_n | ~strobe.wr_n;
  assign stable = (strobe == strobe_prev);

  // count consecutive low samples, saturate so one strobe gives one access
  always_ff @(posedge clk) begin
    if (reset || !low)
      low_cnt <= '0;
    else if (!stable)
      low_cnt <= cnt_w'(1); // strobe just fell or changed kind
    else if (low_cnt != cnt_w'(filter_len))
      low_cnt <= low_cnt + 1'b1;
  end

  assign recog = low && stable && (low_cnt == cnt_w'(filter_len - 1));

  // full map: 12k rom below 0x3000 plus 48k ram, else upper 32k only
  assign rom_sel = full_addr & ~addr[15] & ~addr[14] & ~(addr[13] & addr[12]);
  assign ram_sel = full_addr ? (addr[15] | addr[14]) : addr[15];

  assign rd_go = recog & ~strobe.rd_n & (rom_sel | ram_sel);
  assign wr_go = recog & ~strobe.wr_n & ram_sel; // rom is read only

  assign data_oe = ~strobe.rd_n & (rom_sel | ram_sel);

  always_ff @(posedge clk) begin
    if (reset) begin
      ram_en <= 1'b0;
      ram_we <= 1'b0;
      rd_s1  <= 1'b0;
      rd_s2  <= 1'b0;
    end else begin
      ram_en <= rd_go | wr_go;
      ram_we <= wr_go;
      rd_s1  <= rd_go;
      rd_s2  <= rd_s1;
    end
  end

  always_ff @(posedge clk) begin
    ram_addr  <= addr[addr_w-1:0];
    ram_wdata <= data_in;
    if (rd_s2)
      data_out <= ram_rdata; // held until the next read
  end

endmodule

`default_nettype wire

// File: cmd_exec.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_exec (
  input  logic              clk,
  input  logic              reset,
  input  trs_pkg::cmd_req_t req,
  input  logic [3:0]        conf,
  output logic [7:0]        reply,
  output logic [2:0]        led,
  output logic              full_addr,
  output logic              ram_en,
  output logic              ram_we,
  output logic [14:0]       ram_addr,
  output logic [7:0]        ram_wdata,
  input  logic [7:0]        ram_rdata
);

  logic is_poke;
  logic is_peek;
  logic peek_s1; // port b enabled for a read
  logic peek_s2; // read data on ram_rdata

  assign is_poke = req.valid && (req.cmd == trs_pkg::bram_poke);
  assign is_peek = req.valid && (req.cmd == trs_pkg::bram_peek);

  always_ff @(posedge clk) begin
    if (reset) begin
      ram_en    <= 1'b0;
      ram_we    <= 1'b0;
      peek_s1   <= 1'b0;
      peek_s2   <= 1'b0;
      led       <= 3'd0;
      full_addr <= 1'b0;
    end else begin
      ram_en  <= is_poke | is_peek;
      ram_we  <= is_poke;
      peek_s1 <= is_peek;
      peek_s2 <= peek_s1;
      if (req.valid && req.cmd == trs_pkg::set_led)
        led <= req.p0[2:0]; // red, green, blue
      if (req.valid && req.cmd == trs_pkg::set_full_addr)
        full_addr <= (req.p0 != 8'h00);
    end
  end

  // address is p1 low bits over p0
  always_ff @(posedge clk) begin
    if (req.valid) begin
      ram_addr  <= {req.p1[6:0], req.p0};
      ram_wdata <= req.p2;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      reply <= 8'h00;
    end else if (peek_s2) begin
      reply <= ram_rdata;
    end else if (req.valid) begin
      case (req.cmd)
        trs_pkg::get_cookie:  reply <= trs_pkg::cookie;
        trs_pkg::get_version: reply <= {trs_pkg::version_major, trs_pkg::version_minor};
        trs_pkg::get_config:  reply <= {4'h0, conf};
        default: ;
      endcase
    end
  end

  a_we_needs_en: assert property (
    @(posedge clk) disable iff (reset) ram_we |-> ram_en
  );

endmodule

`default_nettype wire

// File: cmd_parser.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_parser (
  input  logic              clk,
  input  logic              reset,
  input  logic [7:0]        byte_in,
  input  logic              byte_valid,
  input  logic              msg_start,
  output trs_pkg::cmd_req_t req
);

  typedef enum logic {
    idle,
    read_params
  } state_e;

  state_e          state;
  trs_pkg::cmd_e   cmd_q;
  logic [7:0]      params [trs_pkg::max_params];
  logic [1:0]      idx;       // next parameter slot
  logic [1:0]      remaining; // parameters still to come

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      idx       <= 2'd0;
      remaining <= 2'd0;
      req       <= '0;
    end else begin
      req.valid <= 1'b0;
      if (msg_start) begin
        state <= idle; // new message always starts with a command
      end else if (byte_valid) begin
        case (state)
          idle: begin
            cmd_q <= trs_pkg::cmd_e'(byte_in);
            idx   <= 2'd0;
            case (byte_in)
              trs_pkg::get_cookie,
              trs_pkg::get_version,
              trs_pkg::get_config: begin
                req.valid <= 1'b1; // no parameters, fire now
                req.cmd   <= trs_pkg::cmd_e'(byte_in);
              end
              trs_pkg::bram_poke: begin
                remaining <= 2'd3;
                state     <= read_params;
              end
              trs_pkg::bram_peek: begin
                remaining <= 2'd2;
                state     <= read_params;
              end
              trs_pkg::set_full_addr,
              trs_pkg::set_led: begin
                remaining <= 2'd1;
                state     <= read_params;
              end
              default: ; // unknown code, drop it
            endcase
          end
          read_params: begin
            params[idx] <= byte_in;
            idx         <= idx + 2'd1;
            if (remaining == 2'd1) begin
              state     <= idle;
              req.valid <= 1'b1;
              req.cmd   <= cmd_q;
              req.p0    <= (idx == 2'd0) ? byte_in : params[0];
              req.p1    <= (idx == 2'd1) ? byte_in : params[1];
              req.p2    <= (idx == 2'd2) ? byte_in : params[2];
            end else begin
              remaining <= remaining - 2'd1;
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  a_param_idx: assert property (
    @(posedge clk) disable iff (reset)
      (state == read_params) |-> (idx < trs_pkg::max_params)
  );

endmodule

`default_nettype wire

// File: spi_slave.sv
`timescale 1ns/100ps
`default_nettype none

module spi_slave (
  input  logic               clk,
  input  logic               reset,
  input  trs_pkg::spi_pins_t spi,
  output logic               miso,
  input  logic [7:0]         reply,
  output logic [7:0]         byte_in,
  output logic               byte_valid,
  output logic               msg_start
);

  trs_pkg::spi_pins_t pins;
  trs_pkg::spi_pins_t pins_prev;
  logic [2:0] bit_cnt;
  logic [7:0] tx_sr;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;

  pin_sync #(.T(trs_pkg::spi_pins_t)) sync0 (
    .clk  (clk),
    .in   (spi),
    .sync (pins),
    .prev (pins_prev)
  );

  assign sck_rise  = pins.sck & ~pins_prev.sck;
  assign sck_fall  = ~pins.sck & pins_prev.sck;
  assign cs_active = ~pins.cs_n;
  assign msg_start = pins_prev.cs_n & ~pins.cs_n; // cs_n falling

  // receive side
  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt    <= 3'd0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= cs_active & sck_rise & (bit_cnt == 3'd7);
      if (!cs_active)
        bit_cnt <= 3'd0; // idle between messages
      else if (sck_rise)
        bit_cnt <= bit_cnt + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise)
      byte_in <= {byte_in[6:0], pins.mosi}; // msb first
  end

  // transmit side, first bit must sit on miso before the first rise
  always_ff @(posedge clk) begin
    if (reset) begin
      tx_sr <= 8'h00;
    end else if (msg_start) begin
      tx_sr <= reply;
    end else if (cs_active && sck_fall) begin
      if (bit_cnt == 3'd0)
        tx_sr <= reply; // falling edge that closes a byte
      else
        tx_sr <= {tx_sr[6:0], 1'b0};
    end
  end

  assign miso = tx_sr[7];

  a_no_byte_outside_msg: assert property (
    @(posedge clk) disable iff (reset) byte_valid |-> !pins.cs_n
  );

endmodule

`default_nettype wire

// File: pin_sync.sv
`timescale 1ns/100ps
`default_nettype none

module pin_sync #(
  parameter type T = trs_pkg::spi_pins_t
) (
  input  logic clk,
  input  T     in,
  output T     sync,
  output T     prev
);

  T meta; // first stage, may go metastable

  always_ff @(posedge clk) begin
    meta <= in;
    sync <= meta;
    prev <= sync; // held copy for edge detection
  end

endmodule

`default_nettype wire

// File: trs_pkg.sv
`default_nettype none

package trs_pkg;

  // command byte as sent by the microcontroller
  typedef enum logic [7:0] {
    get_cookie    = 8'd0,
    bram_poke     = 8'd1,
    bram_peek     = 8'd2,
    set_full_addr = 8'd14,
    get_version   = 8'd15,
    set_led       = 8'd26,
    get_config    = 8'd27
  } cmd_e;

  localparam logic [7:0] cookie        = 8'haf;
  localparam logic [2:0] version_major = 3'd0;
  localparam logic [4:0] version_minor = 5'd3;

  localparam int max_params = 3; // bram_poke carries the most

  typedef struct packed {
    logic sck;
    logic cs_n;
    logic mosi;
  } spi_pins_t;

  typedef struct packed {
    logic rd_n;
    logic wr_n;
  } z80_ctrl_t;

  // one decoded message from the parser
  typedef struct packed {
    logic       valid; // single cycle
    cmd_e       cmd;
    logic [7:0] p0;
    logic [7:0] p1;
    logic [7:0] p2;
  } cmd_req_t;

endpackage

`default_nettype wire
